/* source/spi_params.svh */
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// bits shifted per transfer
`define SPI_NBITS 24

// chip-select lines, active low
`define SPI_NCSBITS 3

`define SPI_NCLKDIVBITS 5
`define SPI_CLKDIV_RESET 4  // sclk half period is div+1 clocks

`endif

/* source/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  `include "spi_params.svh"

  typedef logic [`SPI_NBITS-1:0]       spi_word_t;
  typedef logic [`SPI_NCSBITS-1:0]     spi_cs_t;     // active low
  typedef logic [`SPI_NCLKDIVBITS-1:0] spi_div_t;
  typedef logic [4:0]                  spi_bitcnt_t;
  typedef logic [31:0]                 wb_data_t;

  // shift engine sequence
  typedef enum logic [1:0] {
    IDLE,
    LEAD,
    SHIFT,
    DONE
  } shift_state_t;

endpackage

`default_nettype wire

/* source/spi_clk_gen.sv */
`default_nettype none

module spi_clk_gen
  import spi_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  input  logic     run_i,
  input  spi_div_t div_i,
  output logic     rise_o,
  output logic     fall_o
);

  spi_div_t cnt;
  logic     phase;  // 0 = next strobe is a rise
  logic     tick;

  assign tick = (cnt == '0);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !run_i) begin
      // park so every transfer starts on a rise
      cnt   <= div_i;
      phase <= 1'b0;
    end else if (tick) begin
      cnt   <= div_i;
      phase <= ~phase;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // strobes only while running
  assign rise_o = run_i && tick && !phase;
  assign fall_o = run_i && tick && phase;

endmodule

`default_nettype wire

/* source/spi_shift_engine.sv */
`default_nettype none

`include "spi_params.svh"

module spi_shift_engine
  import spi_pkg::*;
(
  input  logic      wb_clk_i,
  input  logic      wb_rst_i,
  input  logic      start_i,
  input  spi_cs_t   cs_i,
  input  spi_word_t tx_i,
  input  logic      rise_i,
  input  logic      fall_i,
  input  logic      ack_i,
  output logic      run_o,
  output logic      done_o,
  output spi_word_t rx_word_o,
  output spi_cs_t   cs_n_o,
  output logic      sclk_o,
  output logic      mosi_o,
  input  logic      miso_i
);

  shift_state_t state;
  spi_bitcnt_t  bitcnt;
  spi_word_t    tx_sr;
  spi_word_t    rx_sr;
  logic         last_bit;

  assign last_bit = (bitcnt == spi_bitcnt_t'(`SPI_NBITS - 1));

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state  <= IDLE;
      bitcnt <= '0;
      run_o  <= 1'b0;
      done_o <= 1'b0;
      cs_n_o <= '1;
      sclk_o <= 1'b0;
      mosi_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start_i) begin
            state  <= LEAD;
            bitcnt <= '0;
            cs_n_o <= cs_i;
            mosi_o <= tx_i[`SPI_NBITS-1];  // msb ready before first rise
            run_o  <= 1'b1;
          end
        end
        LEAD: begin
          if (rise_i) begin
            sclk_o <= 1'b1;
            state  <= SHIFT;
          end
        end
        SHIFT: begin
          if (fall_i) begin
            sclk_o <= 1'b0;
            if (last_bit) begin
              state  <= DONE;
              cs_n_o <= '1;
              mosi_o <= 1'b0;
              run_o  <= 1'b0;
              done_o <= 1'b1;
            end else begin
              bitcnt <= bitcnt + 1'b1;
              mosi_o <= tx_sr[`SPI_NBITS-2];
            end
          end else if (rise_i) begin
            sclk_o <= 1'b1;
          end
        end
        DONE: begin
          if (ack_i) begin  // rx word consumed
            done_o <= 1'b0;
            state  <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (state == IDLE && start_i) begin
      tx_sr <= tx_i;
    end else if (state == SHIFT && fall_i) begin
      tx_sr <= tx_sr << 1;
    end
    if (rise_i && (state == LEAD || state == SHIFT)) begin
      rx_sr <= {rx_sr[`SPI_NBITS-2:0], miso_i};  // sample on rising edge
    end
  end

  assign rx_word_o = rx_sr;  // stable from DONE until next start

endmodule

`default_nettype wire

/* source/wb_spi_regs.sv */
`default_nettype none

`include "spi_params.svh"

module wb_spi_regs
  import spi_pkg::*;
(
  input  logic      wb_clk_i,
  input  logic      wb_rst_i,
  input  wb_data_t  wb_adr_i,
  input  wb_data_t  wb_dat_i,
  input  logic [3:0] wb_sel_i,
  input  logic      wb_we_i,
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  output wb_data_t  wb_dat_o,
  output logic      wb_ack_o,
  output logic      wb_err_o,
  input  logic      done_i,
  input  spi_word_t rx_word_i,
  output logic      start_o,
  output logic      ack_o,
  output spi_cs_t   cs_o,
  output spi_word_t tx_o,
  output spi_div_t  div_o
);

  logic      wb_ack;
  logic      wait_q;  // trigger write held until done
  wb_data_t  rdata_q;
  spi_word_t rx_q;
  logic      req;

  assign req = wb_cyc_i && wb_stb_i && !wb_ack;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack  <= 1'b0;
      start_o <= 1'b0;
      ack_o   <= 1'b0;
      wait_q  <= 1'b0;
      cs_o    <= '1;
      tx_o    <= '0;
      div_o   <= spi_div_t'(`SPI_CLKDIV_RESET);
      rx_q    <= '0;
    end else begin
      wb_ack  <= 1'b0;
      start_o <= 1'b0;
      ack_o   <= 1'b0;
      if (wait_q) begin
        if (done_i) begin
          wait_q <= 1'b0;
          rx_q   <= rx_word_i;
          ack_o  <= 1'b1;
          wb_ack <= wb_cyc_i && wb_stb_i;  // release the stalled write
        end
      end else if (req) begin
        if (wb_we_i) begin
          case (wb_adr_i[3:2])
            2'd0: begin
              if (wb_sel_i[0]) begin
                cs_o    <= wb_dat_i[`SPI_NCSBITS-1:0];
                start_o <= 1'b1;
                wait_q  <= 1'b1;
              end else begin
                wb_ack <= 1'b1;  // no cs byte so nothing to start
              end
            end
            2'd1: begin
              wb_ack <= 1'b1;
              for (int b = 0; b < `SPI_NBITS / 8; b++) begin
                if (wb_sel_i[b]) begin
                  tx_o[b*8 +: 8] <= wb_dat_i[b*8 +: 8];
                end
              end
            end
            2'd2: begin
              wb_ack <= 1'b1;
              if (wb_sel_i[0]) begin
                div_o <= wb_dat_i[`SPI_NCLKDIVBITS-1:0];
              end
            end
            default: wb_ack <= 1'b1;
          endcase
        end else begin
          wb_ack <= 1'b1;
        end
      end
    end
  end

  // read data only looked at while acked
  always_ff @(posedge wb_clk_i) begin
    if (req && !wait_q && !wb_we_i) begin
      if (wb_adr_i[3:2] == 2'd0) begin
        rdata_q <= wb_data_t'(rx_q);
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign wb_ack_o = wb_ack;
  assign wb_dat_o = wb_ack ? rdata_q : '0;
  assign wb_err_o = 1'b0;

endmodule

`default_nettype wire

/* source/wb_spi_top.sv */
`default_nettype none

module wb_spi_top
  import spi_pkg::*;
(
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  input  wb_data_t   wb_adr_i,
  input  wb_data_t   wb_dat_i,
  input  logic [3:0] wb_sel_i,
  input  logic       wb_we_i,
  input  logic       wb_cyc_i,
  input  logic       wb_stb_i,
  output wb_data_t   wb_dat_o,
  output logic       wb_ack_o,
  output logic       wb_err_o,
  output spi_cs_t    cs_n_o,
  output logic       sclk_o,
  output logic       mosi_o,
  input  logic       miso_i
);

  logic      start;
  logic      ack;
  logic      run;
  logic      rise;
  logic      fall;
  logic      done;
  spi_cs_t   cs;
  spi_word_t tx_word;
  spi_word_t rx_word;
  spi_div_t  div;

  wb_spi_regs i_regs (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .wb_we_i   (wb_we_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .wb_err_o  (wb_err_o),
    .done_i    (done),
    .rx_word_i (rx_word),
    .start_o   (start),
    .ack_o     (ack),
    .cs_o      (cs),
    .tx_o      (tx_word),
    .div_o     (div)
  );

  spi_clk_gen i_clk_gen (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .run_i    (run),
    .div_i    (div),
    .rise_o   (rise),
    .fall_o   (fall)
  );

  spi_shift_engine i_shift (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .start_i   (start),
    .cs_i      (cs),
    .tx_i      (tx_word),
    .rise_i    (rise),
    .fall_i    (fall),
    .ack_i     (ack),
    .run_o     (run),
    .done_o    (done),
    .rx_word_o (rx_word),
    .cs_n_o    (cs_n_o),
    .sclk_o    (sclk_o),
    .mosi_o    (mosi_o),
    .miso_i    (miso_i)
  );

endmodule

`default_nettype wire

/* test/wb_spi_properties.sv */
`default_nettype none

module wb_spi_properties
  import spi_pkg::*;
(
  input logic     wb_clk_i,
  input logic     wb_rst_i,
  input spi_cs_t  cs_n_o,
  input logic     sclk_o,
  input logic     wb_ack_o,
  input wb_data_t wb_dat_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // no clock while every slave is deselected
  sclk_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (cs_n_o == '1) |-> !sclk_o)
    else $error("sclk_o high while all chip selects are inactive");

  ack_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("wb_ack_o high for two cycles");

  dat_gated: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !wb_ack_o |-> (wb_dat_o == '0))  // read data only with ack
    else $error("wb_dat_o nonzero without wb_ack_o");

endmodule

bind wb_spi_top wb_spi_properties i_props (
  .wb_clk_i (wb_clk_i),
  .wb_rst_i (wb_rst_i),
  .cs_n_o   (cs_n_o),
  .sclk_o   (sclk_o),
  .wb_ack_o (wb_ack_o),
  .wb_dat_o (wb_dat_o)
);

`default_nettype wire

/* test/tb_wb_spi.sv */
`default_nettype none

`include "spi_params.svh"

module tb_wb_spi
  import spi_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NXFER = 9;  // transfers in the whole run
  localparam int WATCHDOG_CYCLES = NXFER * 2 * `SPI_NBITS * 32 + 2000;

  logic        wb_clk_i = 1'b0;
  logic        wb_rst_i;
  wb_data_t    wb_adr_i;
  wb_data_t    wb_dat_i;
  wb_data_t    wb_dat_o;
  logic [3:0]  wb_sel_i;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_ack_o;
  logic        wb_err_o;
  spi_cs_t     cs_n_o;
  logic        sclk_o;
  logic        mosi_o;
  logic        miso_i = 1'b0;

  // slave model / monitor state
  spi_word_t   resp_word;
  spi_word_t   mosi_word = '0;
  spi_cs_t     cs_seen = '1;
  spi_cs_t     cs_n_q = '1;
  logic        sclk_q = 1'b0;
  int          cycle = 0;
  int          rise_cnt = 0;
  int          rise_total = 0;
  int          rise_base;
  int          cs_bad = 0;
  int          last_rise = 0;
  int          per_min = 0;
  int          per_max = 0;
  int          divs[3] = '{0, 4, 31};
  logic [31:0] rng;
  logic [3:0]  sel;
  spi_word_t   tx_model;
  wb_data_t    rd;

  wb_spi_top i_wb_spi_top (.*);

  always #4 wb_clk_i = ~wb_clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic spi_word_t merge_lanes(input spi_word_t old, input wb_data_t data,
                                            input logic [3:0] sel_bits);
    spi_word_t w;
    w = old;
    for (int b = 0; b < `SPI_NBITS / 8; b++) begin
      if (sel_bits[b]) w[b*8 +: 8] = data[b*8 +: 8];  // unselected lanes keep old byte
    end
    return w;
  endfunction

  // expected read word and mosi word for one transfer
  function automatic void spi_reference(input spi_word_t tx, input wb_data_t resp,
                                        output wb_data_t exp_rx, output spi_word_t exp_mosi);
    exp_rx   = {8'h00, resp[`SPI_NBITS-1:0]};
    exp_mosi = tx;
  endfunction

  task automatic check_value(input string name, input wb_data_t exp, input wb_data_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic wb_cycle(input int word, input logic we, input wb_data_t data,
                          input logic [3:0] sel_bits, output wb_data_t rdata);
    @(negedge wb_clk_i);
    wb_adr_i = wb_data_t'(word << 2);
    wb_dat_i = data;
    wb_sel_i = sel_bits;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    do @(negedge wb_clk_i); while (!wb_ack_o);  // watchdog guards this
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_sel_i = '0;
  endtask

  task automatic wb_write(input int word, input wb_data_t data, input logic [3:0] sel_bits);
    wb_data_t ignored;
    wb_cycle(word, 1'b1, data, sel_bits, ignored);
  endtask

  task automatic wb_read(input int word, output wb_data_t data);
    wb_cycle(word, 1'b0, '0, 4'hf, data);
  endtask

  task automatic spi_transfer(input string name, input spi_cs_t cs_pat, input int div);
    wb_data_t  exp_rx;
    spi_word_t exp_mosi;
    wb_data_t  rdata;
    rng = xorshift32(rng);
    resp_word = rng[`SPI_NBITS-1:0];
    spi_reference(tx_model, rng, exp_rx, exp_mosi);
    wb_write(0, wb_data_t'(cs_pat), 4'b0001);  // ack comes back after done
    check_value({name, " mosi"}, wb_data_t'(exp_mosi), wb_data_t'(mosi_word));
    check_value({name, " rising edges"}, `SPI_NBITS, rise_cnt);
    check_value({name, " cs pattern"}, wb_data_t'(cs_pat), wb_data_t'(cs_seen));
    check_value({name, " cs changed"}, 0, cs_bad);
    check_value({name, " cs after"}, wb_data_t'(3'b111), wb_data_t'(cs_n_o));
    check_value({name, " min period"}, 2 * (div + 1), per_min);
    check_value({name, " max period"}, 2 * (div + 1), per_max);
    wb_read(0, rdata);
    check_value({name, " rx word"}, exp_rx, rdata);
  endtask

  // spi slave model on falling edges
  always @(negedge wb_clk_i) begin
    int per;
    cycle = cycle + 1;
    if (cs_n_q == '1 && cs_n_o != '1) begin  // start of transfer
      rise_cnt  = 0;
      cs_bad    = 0;
      cs_seen   = cs_n_o;
      mosi_word = '0;
      per_min   = 1 << 30;
      per_max   = 0;
    end
    if (sclk_o && !sclk_q) begin
      per = cycle - last_rise;
      if (rise_cnt > 0 && per < per_min) per_min = per;
      if (rise_cnt > 0 && per > per_max) per_max = per;
      if (cs_n_o != cs_seen) cs_bad++;
      last_rise  = cycle;
      mosi_word  = {mosi_word[`SPI_NBITS-2:0], mosi_o};
      rise_cnt   = rise_cnt + 1;
      rise_total = rise_total + 1;
    end
    miso_i = (cs_n_o != '1 && rise_cnt < `SPI_NBITS) ? resp_word[`SPI_NBITS-1-rise_cnt] : 1'b0;
    sclk_q = sclk_o;
    cs_n_q = cs_n_o;
  end

  initial begin
    #(WATCHDOG_CYCLES * 8);
    $display("timeout: a bus cycle or spi transfer never completed");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    wb_rst_i  = 1'b1;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    wb_we_i   = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    rng       = 32'h08783773;
    tx_model  = '0;
    resp_word = '0;
    repeat (16) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    wb_rst_i = 1'b0;

    check_value("reset cs_n", wb_data_t'(3'b111), wb_data_t'(cs_n_o));
    check_value("reset sclk", 0, wb_data_t'(sclk_o));
    wb_read(0, rd);
    check_value("reset rx", 0, rd);

    // tx lanes and data at the reset divisor
    for (int i = 0; i < 6; i++) begin
      rng = xorshift32(rng);
      sel = (i == 0) ? 4'hf : rng[31:28];
      wb_write(1, rng, sel);
      tx_model = merge_lanes(tx_model, rng, sel);
      spi_transfer($sformatf("xfer %0d", i), ~(3'b001 << (i % 3)), `SPI_CLKDIV_RESET);
    end

    foreach (divs[k]) begin
      wb_write(2, wb_data_t'(divs[k]), 4'b0001);
      spi_transfer($sformatf("div %0d", divs[k]), 3'b110, divs[k]);
    end

    rise_base = rise_total;
    wb_write(0, 32'h0000_0006, 4'b1110);  // cs byte not selected
    repeat (64) @(negedge wb_clk_i);
    check_value("no start edges", rise_base, rise_total);
    check_value("no start cs", wb_data_t'(3'b111), wb_data_t'(cs_n_o));
    wb_read(1, rd);
    check_value("read adr 1", 0, rd);
    wb_read(3, rd);
    check_value("read adr 3", 0, rd);
    check_value("wb_err", 0, wb_data_t'(wb_err_o));

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+source
source/spi_pkg.sv
source/spi_clk_gen.sv
source/spi_shift_engine.sv
source/wb_spi_regs.sv
source/wb_spi_top.sv
test/wb_spi_properties.sv
test/tb_wb_spi.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f flist.f \
  --top-module tb_wb_spi -o tb_wb_spi && ./obj_dir/tb_wb_spi > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Result: PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
